// File: build.f
+incdir+verif
source/ws2812_pkg.sv
source/pixel_ram.sv
source/bit_encoder.sv
source/frame_sequencer.sv
source/ws2812_top.sv
verif/ws2812_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the WS2812 driver testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    -f build.f \
    --top-module ws2812_tb \
    -o ws2812_sim

./obj_dir/ws2812_sim | tee "$LOG"

if grep -q "ALL CHECKS PASSED" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed, see $LOG"
    exit 1
fi

// File: verif/ws2812_tb_tasks.svh
// Directed tests for the WS2812 driver.
// Each test writes the pixel memory, runs frames and checks the decoded colours.

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    checks++;
    assert (expected === actual) else begin
        errors++;
        $display("mismatch %s expected %h actual %h", name, expected, actual);
    end
endtask

// One host write to a single byte lane, mirrored in the model.
task automatic write_lane(input logic [5:0] addr, input int lane, input logic [7:0] data);
    @(posedge clk_in);
    wr.en      <= 1'b1;
    wr.addr    <= addr;
    wr.byte_en <= 4'b0001 << lane;
    wr.data    <= data;
    model_mem[addr][lane*8 +: 8] = data;
    @(posedge clk_in);
    wr.en <= 1'b0;
endtask

task automatic write_entry(input logic [5:0] addr, input logic [5:0] next,
                           input ws2812_pkg::grb_t color);
    write_lane(addr, 3, {2'b00, next});
    write_lane(addr, 2, color.g);
    write_lane(addr, 1, color.r);
    write_lane(addr, 0, color.b);
endtask

// Walks the model from address 0 until a link of 0.
task automatic predict_chain();
    logic [5:0] addr;
    int         hops;
    exp_colors.delete();
    addr = '0;
    hops = 0;
    do begin
        exp_colors.push_back(model_mem[addr][23:0]);
        addr = model_mem[addr][29:24];
        hops++;
    end while (addr != '0 && hops < 64);
endtask

task automatic run_frame(input string name, input logic restart_while_busy);
    int first;
    int started;
    int limit;
    int waited;
    test_name = name;
    predict_chain();
    first   = rx_colors.size();
    started = frames_started;
    limit   = exp_colors.size() * 24 * (BIT_CYCLES + 1) + RESET_CYCLES + 50;
    waited  = 0;
    @(posedge clk_in);
    frame_start <= 1'b1;
    @(posedge clk_in);
    frame_start <= 1'b0;
    @(negedge clk_in);
    check_value(name, 32'd1, 32'(busy));
    if (restart_while_busy) begin
        repeat (20) @(posedge clk_in);
        frame_start <= 1'b1;
        @(posedge clk_in);
        frame_start <= 1'b0;
        @(negedge clk_in);
    end
    while (busy && waited < limit) begin
        @(negedge clk_in);
        waited++;
    end
    checks++;
    assert (!busy) else begin
        errors++;
        $display("%s: frame still busy after %0d cycles", name, limit);
    end
    // A second frame would have raised busy again by now.
    repeat (10) @(negedge clk_in);
    check_value(name, 32'd0, 32'(busy));
    check_value(name, 32'(started + 1), 32'(frames_started));
    check_value(name, 32'(exp_colors.size()), 32'(rx_colors.size() - first));
    check_value(name, 32'd0, 32'(bit_count));
    for (int i = 0; i < exp_colors.size() && first + i < rx_colors.size(); i++) begin
        check_value(name, 32'(exp_colors[i]), 32'(rx_colors[first + i]));
    end
endtask

task automatic test_idle();
    test_name = "idle";
    repeat (20) begin
        @(negedge clk_in);
        check_value(test_name, 32'd0, 32'({led_out, busy}));
    end
    check_value(test_name, 32'd0, 32'(frames_started));
endtask

task automatic test_single();
    write_entry(6'd0, 6'd0, 24'hC35A81);
    run_frame("single_pixel", 1'b0);
endtask

// Address 1 is written but not linked, so it must never be sent.
task automatic test_chain();
    write_entry(6'd0, 6'd17, 24'($random(seed)));
    write_entry(6'd17, 6'd5, 24'($random(seed)));
    write_entry(6'd5, 6'd0, 24'($random(seed)));
    write_entry(6'd1, 6'd2, 24'($random(seed)));
    run_frame("linked_chain", 1'b0);
endtask

task automatic test_partial();
    write_lane(6'd0, 3, 8'h00);
    write_lane(6'd0, 1, 8'h3C);
    run_frame("partial_write", 1'b0);
endtask

task automatic test_latch();
    write_entry(6'd0, 6'd0, 24'($random(seed)));
    run_frame("latch_and_restart", 1'b1);
endtask

// File: verif/ws2812_tb.sv
// WS2812 driver testbench.
// Drives host writes and frame starts, decodes the serial line back into
// colours and compares them with a model of the linked pixel chain.

module ws2812_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int T0H_CYCLES   = 2;
    localparam int T1H_CYCLES   = 4;
    localparam int BIT_CYCLES   = 7;
    localparam int RESET_CYCLES = 30;

    // Pixels and frames sent by all tests together.
    localparam int TOTAL_PIXELS    = 6;
    localparam int TOTAL_FRAMES    = 4;
    localparam int WORST_CYCLES    = TOTAL_PIXELS * 24 * (BIT_CYCLES + 1)
                                   + TOTAL_FRAMES * (RESET_CYCLES + 60) + 300;
    localparam int WATCHDOG_CYCLES = 2 * WORST_CYCLES + 500;

    logic                  clk_in;
    logic                  rst_n_in;
    ws2812_pkg::pixel_wr_t wr;
    logic                  frame_start;
    logic                  led_out;
    logic                  busy;

    int     errors = 0;
    int     checks = 0;
    int     mon_errors = 0;
    int     mon_checks = 0;
    string  test_name = "reset";
    integer seed = 65;

    logic [31:0] model_mem [64];
    logic [23:0] exp_colors [$];
    logic [23:0] rx_colors [$];

    // Line decoder state.
    logic        led_q = 1'b0;
    logic        busy_q = 1'b0;
    logic        have_rise = 1'b0;
    logic [23:0] rx_shift = '0;
    int          cycle = 0;
    int          last_rise = 0;
    int          high_w = 0;
    int          low_w = 0;
    int          bit_count = 0;
    int          frames_started = 0;

    ws2812_top #(
        .T0H_CYCLES   (T0H_CYCLES),
        .T1H_CYCLES   (T1H_CYCLES),
        .BIT_CYCLES   (BIT_CYCLES),
        .RESET_CYCLES (RESET_CYCLES)
    ) i_ws2812_top (
        .clk_in      (clk_in),
        .rst_n_in    (rst_n_in),
        .wr          (wr),
        .frame_start (frame_start),
        .led_out     (led_out),
        .busy        (busy)
    );

    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Line decoder, sampled on the falling edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk_in) begin
        if (rst_n_in) begin
            cycle++;
            if (busy && !busy_q) begin
                frames_started++;
                bit_count = 0;
                have_rise = 1'b0;
            end
            if (led_out && !led_q) begin
                // Rising edges of one frame sit on a fixed bit grid.
                if (have_rise) begin
                    mon_checks++;
                    assert (cycle - last_rise == BIT_CYCLES + 1) else begin
                        mon_errors++;
                        $display("mismatch %s bit spacing expected %0d actual %0d",
                                 test_name, BIT_CYCLES + 1, cycle - last_rise);
                    end
                end
                have_rise = 1'b1;
                last_rise = cycle;
                high_w    = 1;
            end else if (led_out) begin
                high_w++;
            end
            if (!led_out && led_q) begin
                mon_checks++;
                assert (high_w == T0H_CYCLES || high_w == T1H_CYCLES) else begin
                    mon_errors++;
                    $display("%s: high pulse of %0d cycles is neither a 0 nor a 1 bit",
                             test_name, high_w);
                end
                rx_shift = {rx_shift[22:0], high_w == T1H_CYCLES};
                bit_count++;
                if (bit_count == 24) begin
                    rx_colors.push_back(rx_shift);
                    bit_count = 0;
                end
                low_w = 1;
            end else if (!led_out) begin
                low_w++;
            end
            if (!busy && busy_q) begin
                mon_checks++;
                assert (low_w >= RESET_CYCLES && low_w <= RESET_CYCLES + BIT_CYCLES + 2)
                else begin
                    mon_errors++;
                    $display("%s: line was low for %0d cycles before busy fell",
                             test_name, low_w);
                end
            end
        end
        led_q  = led_out;
        busy_q = busy;
    end

    `include "ws2812_tb_tasks.svh"

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        $display("watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, test_name);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        rst_n_in    = 1'b0;
        frame_start = 1'b0;
        wr          = '0;
        for (int i = 0; i < 64; i++) begin
            model_mem[i] = '0;
        end
        repeat (5) @(posedge clk_in);
        rst_n_in <= 1'b1;

        test_idle();
        test_single();
        test_chain();
        test_partial();
        test_latch();

        $display("checks: %0d, errors: %0d", checks + mon_checks, errors + mon_errors);
        if (errors + mon_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: source/ws2812_top.sv
// WS2812 LED chain driver top level.
// Connects the pixel memory, the frame sequencer and the bit encoder,
// and sets the bit and latch timing in clock cycles.

module ws2812_top #(
    parameter int T0H_CYCLES   = 20,
    parameter int T1H_CYCLES   = 40,
    parameter int BIT_CYCLES   = 63,
    parameter int RESET_CYCLES = 2600
) (
    input  logic                  clk_in,
    input  logic                  rst_n_in,
    input  ws2812_pkg::pixel_wr_t wr,
    input  logic                  frame_start,
    output logic                  led_out,
    output logic                  busy
);

    logic                          rd_en;
    logic [ws2812_pkg::addr_w-1:0] rd_addr;
    ws2812_pkg::pixel_entry_t      rd_entry;
    ws2812_pkg::bit_req_t          bit_req;
    logic                          bit_done;

    pixel_ram i_pixel_ram (
        .clk_in   (clk_in),
        .rst_n_in (rst_n_in),
        .wr       (wr),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_entry (rd_entry)
    );

    frame_sequencer #(
        .RESET_CYCLES (RESET_CYCLES)
    ) i_frame_sequencer (
        .clk_in      (clk_in),
        .rst_n_in    (rst_n_in),
        .frame_start (frame_start),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_entry    (rd_entry),
        .bit_req     (bit_req),
        .bit_done    (bit_done),
        .busy        (busy)
    );

    bit_encoder #(
        .T0H_CYCLES (T0H_CYCLES),
        .T1H_CYCLES (T1H_CYCLES),
        .BIT_CYCLES (BIT_CYCLES)
    ) i_bit_encoder (
        .clk_in   (clk_in),
        .rst_n_in (rst_n_in),
        .bit_req  (bit_req),
        .led_out  (led_out),
        .bit_done (bit_done)
    );

endmodule

// File: source/frame_sequencer.sv
// Frame sequencer.
// Walks the linked pixel chain from address 0, feeds the colour bits to
// the encoder one at a time and holds the line low for the latch gap.

module frame_sequencer #(
    parameter int RESET_CYCLES = 2600
) (
    input  logic                          clk_in,
    input  logic                          rst_n_in,
    input  logic                          frame_start,
    output logic                          rd_en,
    output logic [ws2812_pkg::addr_w-1:0] rd_addr,
    input  ws2812_pkg::pixel_entry_t      rd_entry,
    output ws2812_pkg::bit_req_t          bit_req,
    input  logic                          bit_done,
    output logic                          busy
);

    localparam int RST_CNT_W = $clog2(RESET_CYCLES + 1);

    localparam logic [RST_CNT_W-1:0] LATCH_LAST = RST_CNT_W'(RESET_CYCLES - 1);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_FETCH = 2'd1;
    localparam logic [1:0] ST_SEND  = 2'd2;
    localparam logic [1:0] ST_LATCH = 2'd3;

    logic [1:0]                    state;
    logic                          rd_valid;
    logic [4:0]                    bit_cnt;
    logic [RST_CNT_W-1:0]          latch_cnt;
    logic [23:0]                   shift_reg;
    logic [ws2812_pkg::addr_w-1:0] link;
    logic                          last_bit;
    logic                          load_pixel;

    assign last_bit = bit_done && (bit_cnt == 5'd23);

    // A pixel is loaded from rd_entry either after the first read of the
    // frame or, at the end of a pixel, from the prefetched entry.
    assign load_pixel = ((state == ST_FETCH) && rd_valid) ||
                        ((state == ST_SEND) && last_bit && (link != '0));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pixel shift register and chain link
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_in) begin
        if (load_pixel) begin
            shift_reg <= rd_entry.color;
            link      <= rd_entry.next_addr;
        end else if ((state == ST_SEND) && bit_done) begin
            shift_reg <= {shift_reg[22:0], 1'b0};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            state     <= ST_IDLE;
            busy      <= 1'b0;
            rd_en     <= 1'b0;
            rd_addr   <= '0;
            rd_valid  <= 1'b0;
            bit_cnt   <= '0;
            latch_cnt <= '0;
            bit_req   <= '0;
        end else begin
            rd_en          <= 1'b0;
            rd_valid       <= rd_en;
            bit_req.strobe <= 1'b0;

            // First bit of a new pixel, and the prefetch of its successor
            // so the next entry is ready before the 24th bit is done.
            if (load_pixel) begin
                bit_cnt        <= '0;
                bit_req.strobe <= 1'b1;
                bit_req.value  <= rd_entry.color.g[7];
                if (rd_entry.next_addr != '0) begin
                    rd_en   <= 1'b1;
                    rd_addr <= rd_entry.next_addr;
                end
            end

            case (state)
                ST_IDLE: begin
                    if (frame_start) begin
                        state   <= ST_FETCH;
                        busy    <= 1'b1;
                        rd_en   <= 1'b1;
                        rd_addr <= '0;
                    end
                end
                ST_FETCH: begin
                    if (rd_valid) begin
                        state <= ST_SEND;
                    end
                end
                ST_SEND: begin
                    if (bit_done) begin
                        if (!last_bit) begin
                            bit_cnt        <= bit_cnt + 1'b1;
                            bit_req.strobe <= 1'b1;
                            bit_req.value  <= shift_reg[22];
                        end else if (link == '0) begin
                            state     <= ST_LATCH;
                            latch_cnt <= '0;
                        end
                    end
                end
                ST_LATCH: begin
                    // busy drops in the cycle after the last low cycle.
                    if (latch_cnt == LATCH_LAST) begin
                        state <= ST_IDLE;
                        busy  <= 1'b0;
                    end else begin
                        latch_cnt <= latch_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                    busy  <= 1'b0;
                end
            endcase
        end
    end

endmodule

// File: source/bit_encoder.sv
// WS2812 bit encoder.
// Turns one requested bit into a high pulse of T0H or T1H cycles and a
// low tail, over a period of BIT_CYCLES, then pulses bit_done.

module bit_encoder #(
    parameter int T0H_CYCLES = 20,
    parameter int T1H_CYCLES = 40,
    parameter int BIT_CYCLES = 63
) (
    input  logic                 clk_in,
    input  logic                 rst_n_in,
    input  ws2812_pkg::bit_req_t bit_req,
    output logic                 led_out,
    output logic                 bit_done
);

    localparam int CNT_W = $clog2(BIT_CYCLES + 1);

    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(BIT_CYCLES - 1);
    localparam logic [CNT_W-1:0] T0H_CNT  = CNT_W'(T0H_CYCLES);
    localparam logic [CNT_W-1:0] T1H_CNT  = CNT_W'(T1H_CYCLES);

    logic             active;
    logic             bit_value;
    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] cnt_next;
    logic [CNT_W-1:0] high_cycles;

    assign cnt_next    = cnt + 1'b1;
    assign high_cycles = bit_value ? T1H_CNT : T0H_CNT;

    // The requested bit is latched at each strobe and selects the high time.
    always_ff @(posedge clk_in) begin
        if (bit_req.strobe) begin
            bit_value <= bit_req.value;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Period counter and line driver
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // cnt holds the index of the current cycle within the period, so
    // the outputs are set one cycle ahead from cnt_next.
    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            active   <= 1'b0;
            cnt      <= '0;
            led_out  <= 1'b0;
            bit_done <= 1'b0;
        end else if (bit_req.strobe) begin
            // Every bit starts high, whatever its value.
            active   <= 1'b1;
            cnt      <= '0;
            led_out  <= 1'b1;
            bit_done <= 1'b0;
        end else if (active) begin
            if (cnt == LAST_CNT) begin
                active   <= 1'b0;
                cnt      <= '0;
                led_out  <= 1'b0;
                bit_done <= 1'b0;
            end else begin
                cnt      <= cnt_next;
                led_out  <= (cnt_next < high_cycles);
                bit_done <= (cnt_next == LAST_CNT);
            end
        end else begin
            led_out  <= 1'b0;
            bit_done <= 1'b0;
        end
    end

endmodule

// File: source/pixel_ram.sv
// Pixel memory.
// 64 words with byte lane writes from the host and a registered
// read port used by the frame sequencer.

module pixel_ram (
    input  logic                              clk_in,
    input  logic                              rst_n_in,
    input  ws2812_pkg::pixel_wr_t             wr,
    input  logic                              rd_en,
    input  logic [ws2812_pkg::addr_w-1:0]     rd_addr,
    output ws2812_pkg::pixel_entry_t          rd_entry
);

    localparam int DEPTH = 2 ** ws2812_pkg::addr_w;

    ws2812_pkg::pixel_word_u mem [DEPTH];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Each enabled lane takes the same data byte.
    always_ff @(posedge clk_in) begin
        if (wr.en) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (wr.byte_en[lane]) begin
                    mem[wr.addr].lanes[lane] <= wr.data;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // The entry appears one clock after rd_en and holds until the next
    // read, which lets the sequencer use it as its prefetch buffer.
    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            rd_entry <= '0;
        end else if (rd_en) begin
            rd_entry <= mem[rd_addr].entry;
        end
    end

endmodule

// File: source/ws2812_pkg.sv
// WS2812 driver shared types.
// Pixel memory word layout, colour and entry structs, the host write
// port and the bit request sent from the frame sequencer to the encoder.

package ws2812_pkg;

    // Width of a pixel memory address and of the chain link.
    localparam int addr_w = 6;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pixel data
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // One colour, sent g first and each byte MSB first.
    typedef struct packed {
        logic [7:0] g;
        logic [7:0] r;
        logic [7:0] b;
    } grb_t;

    // A stored entry. A next_addr of 0 ends the chain.
    typedef struct packed {
        logic [1:0]        spare;
        logic [addr_w-1:0] next_addr;
        grb_t              color;
    } pixel_entry_t;

    // Written through the byte lanes, read back as an entry.
    typedef union packed {
        pixel_entry_t    entry;
        logic [3:0][7:0] lanes;
    } pixel_word_u;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Host write. The data byte goes to every lane selected by byte_en.
    typedef struct packed {
        logic              en;
        logic [addr_w-1:0] addr;
        logic [3:0]        byte_en;
        logic [7:0]        data;
    } pixel_wr_t;

    typedef struct packed {
        logic strobe;
        logic value;
    } bit_req_t;

endpackage
